//--- apb_pkg.sv
package apb_pkg;

	// ========================================================================
	// bus widths
	// ========================================================================

	localparam int paddr_w = 16;
	localparam int haddr_w = 32;
	localparam int data_w  = 32;

	// ========================================================================
	// APB request and response
	// ========================================================================

	typedef struct packed {
		logic [paddr_w-1:0] paddr;
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [data_w-1:0]  pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [data_w-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// bridge sequencing states
	typedef enum logic [2:0] {
		br_idle,
		br_rd_setup,
		br_rd_access,
		br_wr_setup,
		br_wr_access,
		br_err_reply
	} bridge_state_e;

	// AHB htrans encoding
	typedef enum logic [1:0] {
		htrans_idle   = 2'b00,
		htrans_busy   = 2'b01,
		htrans_nonseq = 2'b10,
		htrans_seq    = 2'b11
	} htrans_e;

endpackage

//--- ahbl_to_apb.sv
module ahbl_to_apb import apb_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               ahbls_hready,
	output logic               ahbls_hready_resp,
	output logic               ahbls_hresp,
	input  logic [haddr_w-1:0] ahbls_haddr,
	input  logic               ahbls_hwrite,
	input  logic [1:0]         ahbls_htrans,
	input  logic [2:0]         ahbls_hsize,
	input  logic [2:0]         ahbls_hburst,
	input  logic [3:0]         ahbls_hprot,
	input  logic               ahbls_hmastlock,
	input  logic [data_w-1:0]  ahbls_hwdata,
	output logic [data_w-1:0]  ahbls_hrdata,

	output apb_req_t           apb_req,
	input  apb_rsp_t           apb_rsp
);

	bridge_state_e      state;
	bridge_state_e      state_nxt;
	htrans_e            htrans;
	logic               in_access;
	logic               acc_ok;
	logic               acc_err;
	logic               addr_take;
	logic [paddr_w-1:0] paddr_q;
	logic [data_w-1:0]  pwdata_q;

	assign htrans = htrans_e'(ahbls_htrans);

	assign in_access = (state == br_rd_access) || (state == br_wr_access);
	assign acc_ok    = in_access && apb_rsp.pready && !apb_rsp.pslverr;
	assign acc_err   = in_access && apb_rsp.pready && apb_rsp.pslverr;

	// ========================================================================
	// AHB side
	// ========================================================================

	// first error cycle holds hready low, err_reply releases it
	assign ahbls_hready_resp = (state == br_idle) || (state == br_err_reply) || acc_ok;
	assign ahbls_hresp       = acc_err || (state == br_err_reply);
	assign ahbls_hrdata      = apb_rsp.prdata;

	// size, burst, prot and lock are not decoded, every beat is a full-word single
	assign addr_take = ahbls_hready && ahbls_hready_resp &&
		(htrans == htrans_nonseq || htrans == htrans_seq);

	// ========================================================================
	// APB sequencing
	// ========================================================================

	always_comb begin
		state_nxt = state;
		if (addr_take) begin
			state_nxt = ahbls_hwrite ? br_wr_setup : br_rd_setup;
		end else begin
			case (state)
				br_rd_setup:  state_nxt = br_rd_access;
				br_wr_setup:  state_nxt = br_wr_access;
				br_rd_access,
				br_wr_access: begin
					if (apb_rsp.pready)
						state_nxt = apb_rsp.pslverr ? br_err_reply : br_idle;
				end
				default:      state_nxt = br_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= br_idle;
			paddr_q  <= '0;
			pwdata_q <= '0;
		end else begin
			state <= state_nxt;
			if (addr_take)
				paddr_q <= ahbls_haddr[paddr_w-1:0];
			// hwdata belongs to the data phase, which opens with setup
			if (state == br_wr_setup)
				pwdata_q <= ahbls_hwdata;
		end
	end

	always_comb begin
		apb_req.paddr   = paddr_q;
		apb_req.psel    = (state == br_rd_setup) || (state == br_wr_setup) || in_access;
		apb_req.penable = in_access;
		apb_req.pwrite  = (state == br_wr_setup) || (state == br_wr_access);
		// pass hwdata straight through in setup so pwdata is steady from the start
		apb_req.pwdata  = (state == br_wr_setup) ? ahbls_hwdata : pwdata_q;
	end

endmodule

//--- apb_splitter.sv
module apb_splitter import apb_pkg::*; #(
	parameter logic [paddr_w-1:0] slv0_base   = 16'h0000,
	parameter logic [paddr_w-1:0] slv1_base   = 16'h0100,
	parameter int                 region_bits = 8
) (
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp,

	output apb_req_t slv0_req,
	input  apb_rsp_t slv0_rsp,

	output apb_req_t slv1_req,
	input  apb_rsp_t slv1_rsp
);

	logic               hit0;
	logic               hit1;
	logic [paddr_w-1:0] offset;

	// ========================================================================
	// address decode
	// ========================================================================

	assign hit0 = apb_req.paddr[paddr_w-1:region_bits] == slv0_base[paddr_w-1:region_bits];
	assign hit1 = apb_req.paddr[paddr_w-1:region_bits] == slv1_base[paddr_w-1:region_bits];

	// slaves only see the offset inside their own region
	assign offset = {{(paddr_w - region_bits){1'b0}}, apb_req.paddr[region_bits-1:0]};

	always_comb begin
		slv0_req       = apb_req;
		slv0_req.paddr = offset;
		slv0_req.psel  = apb_req.psel && hit0;
	end

	always_comb begin
		slv1_req       = apb_req;
		slv1_req.paddr = offset;
		// slave 0 wins if both bases decode the same
		slv1_req.psel  = apb_req.psel && hit1 && !hit0;
	end

	// ========================================================================
	// response mux
	// ========================================================================

	always_comb begin
		if (hit0) begin
			apb_rsp = slv0_rsp;
		end else if (hit1) begin
			apb_rsp = slv1_rsp;
		end else begin
			// hole in the map: finish in the first access cycle with an error
			apb_rsp.prdata  = '0;
			apb_rsp.pready  = 1'b1;
			apb_rsp.pslverr = apb_req.psel && apb_req.penable;
		end
	end

endmodule

//--- apb_regbank.sv
module apb_regbank import apb_pkg::*; #(
	parameter int n_regs = 8,
	parameter int n_wait = 0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	localparam int idx_w = (n_regs > 1) ? $clog2(n_regs) : 1;
	localparam int cnt_w = (n_wait > 0) ? $clog2(n_wait + 1) : 1;

	logic [data_w-1:0]  regs [n_regs];
	logic [cnt_w-1:0]   wait_cnt;
	logic [paddr_w-3:0] word_idx;
	logic [idx_w-1:0]   reg_sel;
	logic               access;
	logic               done;
	logic               in_range;

	assign access   = apb_req.psel && apb_req.penable;
	assign done     = access && (wait_cnt == cnt_w'(n_wait));

	// word addressed, byte lane bits ignored
	assign word_idx = apb_req.paddr[paddr_w-1:2];
	assign reg_sel  = word_idx[idx_w-1:0];
	assign in_range = word_idx < n_regs;

	// ========================================================================
	// wait states
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (done) begin
			wait_cnt <= '0;
		end else if (access) begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// ========================================================================
	// register array
	// ========================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < n_regs; i++)
				regs[i] <= '0;
		end else if (done && apb_req.pwrite && in_range) begin
			regs[reg_sel] <= apb_req.pwdata;
		end
	end

	always_comb begin
		apb_rsp.pready  = done;
		apb_rsp.pslverr = done && !in_range;
		apb_rsp.prdata  = '0;
		// out-of-range reads return zero along with the error
		if (done && !apb_req.pwrite && in_range)
			apb_rsp.prdata = regs[reg_sel];
	end

endmodule

//--- apb_subsys_top.sv
module apb_subsys_top import apb_pkg::*; #(
	parameter logic [paddr_w-1:0] slv0_base   = 16'h0000,
	parameter logic [paddr_w-1:0] slv1_base   = 16'h0100,
	parameter int                 region_bits = 8,
	parameter int                 n_regs0     = 8,
	parameter int                 n_regs1     = 4,
	parameter int                 n_wait0     = 0,
	parameter int                 n_wait1     = 2
) (
	input  logic               clk,
	input  logic               rst_n,

	input  logic               ahbls_hready,
	output logic               ahbls_hready_resp,
	output logic               ahbls_hresp,
	input  logic [haddr_w-1:0] ahbls_haddr,
	input  logic               ahbls_hwrite,
	input  logic [1:0]         ahbls_htrans,
	input  logic [2:0]         ahbls_hsize,
	input  logic [2:0]         ahbls_hburst,
	input  logic [3:0]         ahbls_hprot,
	input  logic               ahbls_hmastlock,
	input  logic [data_w-1:0]  ahbls_hwdata,
	output logic [data_w-1:0]  ahbls_hrdata
);

	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	apb_req_t slv0_req;
	apb_rsp_t slv0_rsp;
	apb_req_t slv1_req;
	apb_rsp_t slv1_rsp;

	ahbl_to_apb ahbl_to_apb_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.ahbls_hready      (ahbls_hready),
		.ahbls_hready_resp (ahbls_hready_resp),
		.ahbls_hresp       (ahbls_hresp),
		.ahbls_haddr       (ahbls_haddr),
		.ahbls_hwrite      (ahbls_hwrite),
		.ahbls_htrans      (ahbls_htrans),
		.ahbls_hsize       (ahbls_hsize),
		.ahbls_hburst      (ahbls_hburst),
		.ahbls_hprot       (ahbls_hprot),
		.ahbls_hmastlock   (ahbls_hmastlock),
		.ahbls_hwdata      (ahbls_hwdata),
		.ahbls_hrdata      (ahbls_hrdata),
		.apb_req           (apb_req),
		.apb_rsp           (apb_rsp)
	);

	apb_splitter #(
		.slv0_base   (slv0_base),
		.slv1_base   (slv1_base),
		.region_bits (region_bits)
	) apb_splitter_i (
		.apb_req  (apb_req),
		.apb_rsp  (apb_rsp),
		.slv0_req (slv0_req),
		.slv0_rsp (slv0_rsp),
		.slv1_req (slv1_req),
		.slv1_rsp (slv1_rsp)
	);

	// bank 0 answers without wait states, bank 1 is the slow one
	apb_regbank #(
		.n_regs (n_regs0),
		.n_wait (n_wait0)
	) apb_regbank0_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (slv0_req),
		.apb_rsp (slv0_rsp)
	);

	apb_regbank #(
		.n_regs (n_regs1),
		.n_wait (n_wait1)
	) apb_regbank1_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.apb_req (slv1_req),
		.apb_rsp (slv1_rsp)
	);

endmodule

//--- apb_subsys_checker.sv
module apb_subsys_checker import apb_pkg::*; (
	input logic          clk,
	input logic          rst_n,
	input bridge_state_e state,
	input apb_req_t      apb_req,
	input apb_rsp_t      apb_rsp,
	input logic          ahbls_hready_resp,
	input logic          ahbls_hresp
);
	timeunit 1ns;
	timeprecision 1ps;

	logic setup;
	logic access_end;

	assign setup      = apb_req.psel && !apb_req.penable;
	assign access_end = apb_req.psel && apb_req.penable && apb_rsp.pready;

	// an access cycle only follows a cycle that already had psel high
	penable_needs_psel: assert property (
		@(posedge clk) disable iff (!rst_n)
		apb_req.penable |-> apb_req.psel && $past(apb_req.psel)
	) else $error("penable high without psel held since setup");

	// request holds from setup through the last access cycle
	req_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(apb_req.psel && !access_end) |=> apb_req.psel && $stable(apb_req.paddr) &&
			$stable(apb_req.pwrite) && $stable(apb_req.pwdata)
	) else $error("APB request changed before pready");

	setup_then_access: assert property (
		@(posedge clk) disable iff (!rst_n)
		setup |=> apb_req.psel && apb_req.penable
	) else $error("APB setup not followed by access");

	// two-cycle AHB error reply
	error_two_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		(ahbls_hresp && !ahbls_hready_resp) |=>
			(state == br_err_reply) && ahbls_hresp && ahbls_hready_resp
	) else $error("AHB error reply missing its second cycle");

endmodule

bind ahbl_to_apb apb_subsys_checker apb_subsys_checker_i (
	.clk               (clk),
	.rst_n             (rst_n),
	.state             (state),
	.apb_req           (apb_req),
	.apb_rsp           (apb_rsp),
	.ahbls_hready_resp (ahbls_hready_resp),
	.ahbls_hresp       (ahbls_hresp)
);

//--- tb_apb_subsys.sv
module tb_apb_subsys import apb_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [paddr_w-1:0] slv0_base   = 16'h0000;
	localparam logic [paddr_w-1:0] slv1_base   = 16'h0100;
	localparam int                 region_bits = 8;
	localparam int                 n_regs0     = 8;
	localparam int                 n_regs1     = 4;
	localparam int                 n_wait0     = 0;
	localparam int                 n_wait1     = 2;
	localparam logic [31:0]        seed        = 32'h3e06763b;
	localparam int                 xfer_limit  = 20;

	typedef struct packed {
		logic [haddr_w-1:0] addr;
		logic               write;
		logic [data_w-1:0]  wdata;
	} xfer_t;

	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic              err;
		logic              err_first;
		logic [7:0]        cycles;
	} result_t;

	logic               clk;
	logic               rst_n;
	logic               ahbls_hready;
	logic               ahbls_hready_resp;
	logic               ahbls_hresp;
	logic [haddr_w-1:0] ahbls_haddr;
	logic               ahbls_hwrite;
	logic [1:0]         ahbls_htrans;
	logic [2:0]         ahbls_hsize;
	logic [2:0]         ahbls_hburst;
	logic [3:0]         ahbls_hprot;
	logic               ahbls_hmastlock;
	logic [data_w-1:0]  ahbls_hwdata;
	logic [data_w-1:0]  ahbls_hrdata;

	xfer_t             xfer_q[$];
	result_t           exp_q[$];
	result_t           got_q[$];
	logic [data_w-1:0] model0 [n_regs0];
	logic [data_w-1:0] model1 [n_regs1];
	logic [31:0]       lfsr;
	int                checks;
	int                errors;
	int                test_num;
	int                test_checks;
	int                test_errs;

	apb_subsys_top #(
		.slv0_base   (slv0_base),
		.slv1_base   (slv1_base),
		.region_bits (region_bits),
		.n_regs0     (n_regs0),
		.n_regs1     (n_regs1),
		.n_wait0     (n_wait0),
		.n_wait1     (n_wait1)
	) apb_subsys_top_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ========================================================================
	// stimulus and reference model
	// ========================================================================

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// region 0 and 1 are the banks, region 2 is a hole in the map
	function automatic logic [haddr_w-1:0] make_addr(input int region, input bit in_range);
		logic [paddr_w-region_bits-1:0] page;
		logic [region_bits-3:0]         word;
		int                             n;
		n    = (region == 1) ? n_regs1 : n_regs0;
		page = (region == 1) ? slv1_base[paddr_w-1:region_bits] :
			slv0_base[paddr_w-1:region_bits];
		if (region == 2) begin
			page = 8'(rand_bits(8));
			if (page == slv0_base[paddr_w-1:region_bits] ||
				page == slv1_base[paddr_w-1:region_bits])
				page = page | 8'h10;
			word = 6'(rand_bits(6));
		end else if (in_range) begin
			word = 6'(rand_bits(6) % n);
		end else begin
			word = 6'(n + rand_bits(6) % (64 - n));
		end
		// upper half of haddr is not forwarded, so it is random
		return {16'(rand_bits(16)), page, word, 2'b00};
	endfunction

	function automatic result_t model_xfer(input xfer_t x);
		result_t                        r;
		logic [paddr_w-region_bits-1:0] page;
		int                             word;
		bit                             bank1;
		int                             n;
		int                             w;
		r     = '0;
		page  = x.addr[paddr_w-1:region_bits];
		word  = int'(x.addr[region_bits-1:2]);
		bank1 = page == slv1_base[paddr_w-1:region_bits];
		n     = bank1 ? n_regs1 : n_regs0;
		w     = bank1 ? n_wait1 : n_wait0;
		if (page != slv0_base[paddr_w-1:region_bits] && !bank1) begin
			r.err       = 1'b1;
			r.err_first = 1'b1;
			r.cycles    = 8'd3;
		end else if (word >= n) begin
			r.err       = 1'b1;
			r.err_first = 1'b1;
			r.cycles    = 8'(3 + w);
		end else begin
			r.cycles = 8'(2 + w);
			if (x.write && bank1)
				model1[word] = x.wdata;
			else if (x.write)
				model0[word] = x.wdata;
			else
				r.rdata = bank1 ? model1[word] : model0[word];
		end
		return r;
	endfunction

	function automatic void add_xfer(input logic [haddr_w-1:0] addr, input logic write,
		input logic [data_w-1:0] wdata);
		xfer_t x;
		x.addr  = addr;
		x.write = write;
		x.wdata = wdata;
		xfer_q.push_back(x);
		exp_q.push_back(model_xfer(x));
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ========================================================================
	// AHB-Lite master
	// ========================================================================

	// runs the queued transfers, each new address phase in the last data-phase cycle
	task automatic run_xfers();
		int                issued;
		int                pending;
		int                active;
		int                guard;
		logic              rdy;
		logic              rsp;
		logic              prev_rsp;
		logic [7:0]        cycles;
		logic [data_w-1:0] rd;
		result_t           r;
		issued   = 0;
		pending  = -1;
		active   = -1;
		guard    = 0;
		prev_rsp = 1'b0;
		cycles   = '0;
		while ((issued < xfer_q.size() || pending >= 0 || active >= 0) &&
			guard < xfer_limit * xfer_q.size()) begin
			@(negedge clk);
			guard++;
			rdy = ahbls_hready_resp;
			rsp = ahbls_hresp;
			rd  = ahbls_hrdata;
			ahbls_hready = rdy;
			if (pending >= 0) begin
				active       = pending;
				pending      = -1;
				cycles       = '0;
				prev_rsp     = 1'b0;
				ahbls_hwdata = xfer_q[active].write ? xfer_q[active].wdata : '0;
			end
			if (active >= 0) begin
				cycles = cycles + 8'd1;
				if (rdy) begin
					r = '{rdata: rd, err: rsp, err_first: prev_rsp, cycles: cycles};
					got_q.push_back(r);
					active = -1;
				end
				prev_rsp = rsp;
			end
			if (rdy && issued < xfer_q.size()) begin
				ahbls_htrans = htrans_nonseq;
				ahbls_haddr  = xfer_q[issued].addr;
				ahbls_hwrite = xfer_q[issued].write;
				pending      = issued;
				issued++;
			end else begin
				ahbls_htrans = htrans_idle;
			end
		end
		if (issued < xfer_q.size() || pending >= 0 || active >= 0) begin
			$display("timeout: transfer %0d never completed on the AHB side", active);
			$display("TB FAILED");
			$finish;
		end
	endtask

	task automatic run_and_check();
		run_xfers();
		for (int i = 0; i < xfer_q.size(); i++) begin
			if (!xfer_q[i].write)
				compare("hrdata", got_q[i].rdata, exp_q[i].rdata);
			compare("hresp", 32'(got_q[i].err), 32'(exp_q[i].err));
			compare("hresp first error cycle", 32'(got_q[i].err_first),
				32'(exp_q[i].err_first));
			compare("data phase cycles", 32'(got_q[i].cycles), 32'(exp_q[i].cycles));
		end
		xfer_q.delete();
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic ahb_write(input logic [haddr_w-1:0] addr, input logic [data_w-1:0] wdata);
		add_xfer(addr, 1'b1, wdata);
		run_and_check();
	endtask

	task automatic ahb_read(input logic [haddr_w-1:0] addr);
		add_xfer(addr, 1'b0, '0);
		run_and_check();
	endtask

	task automatic random_single(input int region, input bit in_range);
		logic [haddr_w-1:0] addr;
		logic               write;
		addr  = make_addr(region, in_range);
		write = 1'(rand_bits(1));
		if (write)
			ahb_write(addr, rand_bits(32));
		else
			ahb_read(addr);
	endtask

	task automatic read_all();
		for (int i = 0; i < n_regs0; i++)
			ahb_read(32'(slv0_base) + 32'(4 * i));
		for (int i = 0; i < n_regs1; i++)
			ahb_read(32'(slv1_base) + 32'(4 * i));
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - test_checks, errors - test_errs);
		test_num++;
		test_checks = checks;
		test_errs   = errors;
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================

	initial begin
		int                 region;
		bit                 in_range;
		logic               write;
		logic [haddr_w-1:0] addr;
		logic [data_w-1:0]  wdata;
		lfsr            = seed;
		checks          = 0;
		errors          = 0;
		test_num        = 1;
		test_checks     = 0;
		test_errs       = 0;
		rst_n           = 1'b0;
		ahbls_hready    = 1'b1;
		ahbls_haddr     = '0;
		ahbls_hwrite    = 1'b0;
		ahbls_htrans    = htrans_idle;
		ahbls_hsize     = 3'b010;
		ahbls_hburst    = 3'b000;
		ahbls_hprot     = 4'b0011;
		ahbls_hmastlock = 1'b0;
		ahbls_hwdata    = '0;
		for (int i = 0; i < n_regs0; i++)
			model0[i] = '0;
		for (int i = 0; i < n_regs1; i++)
			model1[i] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		compare("hready_resp", 32'(ahbls_hready_resp), 1);
		compare("hresp", 32'(ahbls_hresp), 0);
		read_all();
		end_test("reset values");

		repeat (40) random_single(0, 1'b1);
		end_test("slave 0 random");

		repeat (30) random_single(1, 1'b1);
		end_test("slave 1 wait states");

		repeat (10) random_single(0, 1'b0);
		repeat (10) random_single(1, 1'b0);
		read_all();
		end_test("out of range offsets");

		repeat (16) random_single(2, 1'b1);
		end_test("unmapped addresses");

		// mostly valid traffic with a few errors mixed in
		repeat (40) begin
			region   = int'(rand_bits(2));
			region   = (region == 3) ? 0 : region;
			in_range = (region == 2) || (rand_bits(3) != 0);
			addr     = make_addr(region, in_range);
			write    = 1'(rand_bits(1));
			wdata    = rand_bits(32);
			add_xfer(addr, write, wdata);
		end
		run_and_check();
		read_all();
		end_test("back to back");

		$display("tests %0d, checks %0d, errors %0d", test_num - 1, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
apb_pkg.sv
ahbl_to_apb.sv
apb_splitter.sv
apb_regbank.sv
apb_subsys_top.sv
apb_subsys_checker.sv
tb_apb_subsys.sv

//--- Bender.yml
package:
  name: apb_subsys

sources:
  - files:
      - apb_pkg.sv
      - ahbl_to_apb.sv
      - apb_splitter.sv
      - apb_regbank.sv
      - apb_subsys_top.sv
  - target: test
    files:
      - apb_subsys_checker.sv
      - tb_apb_subsys.sv
